/* src/periph_pkg.sv */
package periph_pkg;

	////////////////////////////////////////////////////////////
	// Bus and register widths
	////////////////////////////////////////////////////////////
	localparam int BUS_DW    = 32;
	localparam int REG_DW    = 8;
	localparam int BUS_AW    = 8;

	// Block select in adr[7:4], register offset in adr[1:0]
	localparam int SLV_W     = 4;
	localparam int REG_OFS_W = 2;

	typedef enum logic [1:0] {
		SLV_GPIO = 2'd0,
		SLV_FIFO = 2'd1,
		SLV_IRQ  = 2'd2,
		SLV_NONE = 2'd3
	} slave_e;

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_ACK  = 1'b1
	} bus_state_e;

	////////////////////////////////////////////////////////////
	// Register offsets
	////////////////////////////////////////////////////////////
	localparam logic [REG_OFS_W-1:0] GPIO_DATA = 2'd0;
	localparam logic [REG_OFS_W-1:0] GPIO_DIR  = 2'd1;
	localparam logic [REG_OFS_W-1:0] FIFO_DATA = 2'd0;
	localparam logic [REG_OFS_W-1:0] FIFO_STAT = 2'd1;
	localparam logic [REG_OFS_W-1:0] IRQ_PEND  = 2'd0;
	localparam logic [REG_OFS_W-1:0] IRQ_MASK  = 2'd1;

	// Interrupt source bits
	localparam int IRQ_GPIO = 0;
	localparam int IRQ_FIFO = 1;
	localparam int IRQ_N    = 2;

endpackage

/* src/stream_fifo.sv */
`timescale 1ns/100ps

module stream_fifo #(
	parameter int DEPTH = 8
) (
	input  logic                            wb_clk_i,
	input  logic                            rst_i,
	input  logic                            push_i,
	input  logic [periph_pkg::REG_DW-1:0]   push_dat_i,
	input  logic                            pop_i,
	output logic [periph_pkg::REG_DW-1:0]   head_o,
	output logic                            full_o,
	output logic                            empty_o
);

	localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = AW + 1;

	logic [periph_pkg::REG_DW-1:0] mem [DEPTH];
	logic [AW-1:0]                 wr_ptr_q;
	logic [AW-1:0]                 rd_ptr_q;
	logic [CNT_W-1:0]              count_q;
	logic                          do_push;
	logic                          do_pop;

	// Overflow and underflow attempts are dropped
	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & ~empty_o;

	assign full_o  = (count_q == CNT_W'(DEPTH));
	assign empty_o = (count_q == '0);

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////
	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// Storage
	always_ff @(posedge wb_clk_i) begin
		if (do_push) begin
			mem[wr_ptr_q] <= push_dat_i;
		end
	end

	// First word falls through
	assign head_o = mem[rd_ptr_q];

endmodule

/* src/periph_bus_ctrl.sv */
`timescale 1ns/100ps

module periph_bus_ctrl (
	input  logic                                wb_clk_i,
	input  logic                                rst_i,
	input  logic                                wb_cyc_i,
	input  logic                                wb_stb_i,
	input  logic                                wb_we_i,
	input  logic [periph_pkg::BUS_AW-1:0]       wb_adr_i,
	input  logic [3:0]                          wb_sel_i,
	input  logic [periph_pkg::BUS_DW-1:0]       wb_dat_i,
	output logic [periph_pkg::BUS_DW-1:0]       wb_dat_o,
	output logic                                wb_ack_o,
	output logic [periph_pkg::REG_OFS_W-1:0]    reg_ofs_o,
	output logic [periph_pkg::REG_DW-1:0]       reg_wdat_o,
	output logic                                gpio_we_o,
	output logic                                fifo_we_o,
	output logic                                fifo_re_o,
	output logic                                irq_we_o,
	input  logic [periph_pkg::REG_DW-1:0]       gpio_rdat_i,
	input  logic [periph_pkg::REG_DW-1:0]       fifo_rdat_i,
	input  logic [periph_pkg::REG_DW-1:0]       irq_rdat_i
);

	periph_pkg::bus_state_e                 state_q;
	periph_pkg::slave_e                     slv_dec;
	periph_pkg::slave_e                     slv_q;
	logic                                   we_q;
	logic [periph_pkg::REG_OFS_W-1:0]       ofs_q;
	logic [periph_pkg::REG_DW-1:0]          lane_dat;
	logic [periph_pkg::REG_DW-1:0]          wdat_q;
	logic [periph_pkg::REG_DW-1:0]          rdat_sel;
	logic                                   req;
	logic                                   ack;

	assign req = wb_cyc_i & wb_stb_i;
	assign ack = (state_q == periph_pkg::ST_ACK);

	////////////////////////////////////////////////////////////
	// Address decode and byte lane narrowing
	////////////////////////////////////////////////////////////
	always_comb begin
		case (wb_adr_i[periph_pkg::BUS_AW-1 -: periph_pkg::SLV_W])
			0:       slv_dec = periph_pkg::SLV_GPIO;
			1:       slv_dec = periph_pkg::SLV_FIFO;
			2:       slv_dec = periph_pkg::SLV_IRQ;
			default: slv_dec = periph_pkg::SLV_NONE;
		endcase
	end

	// Only one sel bit is set, so the loop picks a single lane
	always_comb begin
		lane_dat = '0;
		for (int i = 0; i < 4; i++) begin
			if (wb_sel_i[i]) begin
				lane_dat = wb_dat_i[i*periph_pkg::REG_DW +: periph_pkg::REG_DW];
			end
		end
	end

	// Two-state handshake FSM
	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			state_q <= periph_pkg::ST_IDLE;
		end else begin
			case (state_q)
				periph_pkg::ST_IDLE: begin
					if (req) begin
						state_q <= periph_pkg::ST_ACK;
					end
				end
				default: state_q <= periph_pkg::ST_IDLE;
			endcase
		end
	end

	// Request fields held for the ack cycle
	always_ff @(posedge wb_clk_i) begin
		if ((state_q == periph_pkg::ST_IDLE) && req) begin
			slv_q  <= slv_dec;
			we_q   <= wb_we_i;
			ofs_q  <= wb_adr_i[periph_pkg::REG_OFS_W-1:0];
			wdat_q <= lane_dat;
		end
	end

	////////////////////////////////////////////////////////////
	// Block strobes and read return
	////////////////////////////////////////////////////////////
	assign gpio_we_o = ack & we_q & (slv_q == periph_pkg::SLV_GPIO);
	assign fifo_we_o = ack & we_q & (slv_q == periph_pkg::SLV_FIFO);
	assign fifo_re_o = ack & ~we_q & (slv_q == periph_pkg::SLV_FIFO);
	assign irq_we_o  = ack & we_q & (slv_q == periph_pkg::SLV_IRQ);

	always_comb begin
		case (slv_q)
			periph_pkg::SLV_GPIO: rdat_sel = gpio_rdat_i;
			periph_pkg::SLV_FIFO: rdat_sel = fifo_rdat_i;
			periph_pkg::SLV_IRQ:  rdat_sel = irq_rdat_i;
			default:              rdat_sel = '0;
		endcase
	end

	// Same byte on every lane
	assign wb_dat_o   = {4{rdat_sel}};
	assign wb_ack_o   = ack;
	assign reg_ofs_o  = ofs_q;
	assign reg_wdat_o = wdat_q;

endmodule

/* src/gpio_port.sv */
`timescale 1ns/100ps

module gpio_port #(
	parameter int GPIO_W = 8
) (
	input  logic                                wb_clk_i,
	input  logic                                rst_i,
	input  logic [periph_pkg::REG_OFS_W-1:0]    reg_ofs_i,
	input  logic [periph_pkg::REG_DW-1:0]       reg_wdat_i,
	input  logic                                reg_we_i,
	output logic [periph_pkg::REG_DW-1:0]       reg_rdat_o,
	input  logic [GPIO_W-1:0]                   gpio_i,
	output logic [GPIO_W-1:0]                   gpio_o,
	output logic [GPIO_W-1:0]                   gpio_oe_o,
	output logic                                gpio_event_o
);

	logic [GPIO_W-1:0] out_q;
	logic [GPIO_W-1:0] dir_q;
	logic [GPIO_W-1:0] in_q;
	logic [GPIO_W-1:0] in_prev_q;

	// Output and direction registers, 1 = driven
	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			out_q <= '0;
			dir_q <= '0;
		end else if (reg_we_i) begin
			if (reg_ofs_i == periph_pkg::GPIO_DATA) begin
				out_q <= reg_wdat_i[GPIO_W-1:0];
			end
			if (reg_ofs_i == periph_pkg::GPIO_DIR) begin
				dir_q <= reg_wdat_i[GPIO_W-1:0];
			end
		end
	end

	// Input sampling and change detect
	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			in_q      <= '0;
			in_prev_q <= '0;
		end else begin
			in_q      <= gpio_i;
			in_prev_q <= in_q;
		end
	end

	assign gpio_event_o = |(in_q ^ in_prev_q);

	// Driven bits read back from the output register
	always_comb begin
		reg_rdat_o = '0;
		case (reg_ofs_i)
			periph_pkg::GPIO_DATA: reg_rdat_o[GPIO_W-1:0] = (out_q & dir_q) | (in_q & ~dir_q);
			periph_pkg::GPIO_DIR:  reg_rdat_o[GPIO_W-1:0] = dir_q;
			default:               reg_rdat_o = '0;
		endcase
	end

	assign gpio_o    = out_q;
	assign gpio_oe_o = dir_q;

endmodule

/* src/fifo_bridge.sv */
`timescale 1ns/100ps

module fifo_bridge #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                                wb_clk_i,
	input  logic                                rst_i,
	input  logic [periph_pkg::REG_OFS_W-1:0]    reg_ofs_i,
	input  logic [periph_pkg::REG_DW-1:0]       reg_wdat_i,
	input  logic                                reg_we_i,
	input  logic                                reg_re_i,
	output logic [periph_pkg::REG_DW-1:0]       reg_rdat_o,
	input  logic [periph_pkg::REG_DW-1:0]       s2m_dat_i,
	input  logic                                s2m_we_i,
	output logic                                s2m_full_o,
	output logic                                s2m_empty_o,
	output logic [periph_pkg::REG_DW-1:0]       m2s_dat_o,
	input  logic                                m2s_re_i,
	output logic                                m2s_full_o,
	output logic                                m2s_empty_o,
	output logic                                fifo_event_o
);

	logic [periph_pkg::REG_DW-1:0] s2m_head;
	logic                          data_sel;

	assign data_sel = (reg_ofs_i == periph_pkg::FIFO_DATA);

	////////////////////////////////////////////////////////////
	// Stream to bus
	////////////////////////////////////////////////////////////
	stream_fifo #(
		.DEPTH      (FIFO_DEPTH)
	) u_s2m (
		.wb_clk_i   (wb_clk_i),
		.rst_i      (rst_i),
		.push_i     (s2m_we_i),
		.push_dat_i (s2m_dat_i),
		.pop_i      (reg_re_i & data_sel),
		.head_o     (s2m_head),
		.full_o     (s2m_full_o),
		.empty_o    (s2m_empty_o)
	);

	////////////////////////////////////////////////////////////
	// Bus to stream
	////////////////////////////////////////////////////////////
	stream_fifo #(
		.DEPTH      (FIFO_DEPTH)
	) u_m2s (
		.wb_clk_i   (wb_clk_i),
		.rst_i      (rst_i),
		.push_i     (reg_we_i & data_sel),
		.push_dat_i (reg_wdat_i),
		.pop_i      (m2s_re_i),
		.head_o     (m2s_dat_o),
		.full_o     (m2s_full_o),
		.empty_o    (m2s_empty_o)
	);

	// Data window returns zero when s2m is empty
	always_comb begin
		case (reg_ofs_i)
			periph_pkg::FIFO_DATA: reg_rdat_o = s2m_empty_o ? '0 : s2m_head;
			periph_pkg::FIFO_STAT: begin
				reg_rdat_o    = '0;
				reg_rdat_o[3:0] = {m2s_full_o, m2s_empty_o, s2m_full_o, s2m_empty_o};
			end
			default:               reg_rdat_o = '0;
		endcase
	end

	// Level event while data waits for the bus
	assign fifo_event_o = ~s2m_empty_o;

endmodule

/* src/irq_ctrl.sv */
`timescale 1ns/100ps

module irq_ctrl (
	input  logic                                wb_clk_i,
	input  logic                                rst_i,
	input  logic [periph_pkg::REG_OFS_W-1:0]    reg_ofs_i,
	input  logic [periph_pkg::REG_DW-1:0]       reg_wdat_i,
	input  logic                                reg_we_i,
	output logic [periph_pkg::REG_DW-1:0]       reg_rdat_o,
	input  logic                                gpio_event_i,
	input  logic                                fifo_event_i,
	output logic                                irq_o
);

	logic [periph_pkg::IRQ_N-1:0] pend_q;
	logic [periph_pkg::IRQ_N-1:0] mask_q;
	logic [periph_pkg::IRQ_N-1:0] events;
	logic [periph_pkg::IRQ_N-1:0] pend_clr;

	always_comb begin
		events                      = '0;
		events[periph_pkg::IRQ_GPIO] = gpio_event_i;
		events[periph_pkg::IRQ_FIFO] = fifo_event_i;
	end

	// Write one to clear
	assign pend_clr = (reg_we_i && (reg_ofs_i == periph_pkg::IRQ_PEND)) ?
		reg_wdat_i[periph_pkg::IRQ_N-1:0] : '0;

	// A new event beats a clear in the same cycle
	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			pend_q <= '0;
			mask_q <= '0;
		end else begin
			pend_q <= (pend_q & ~pend_clr) | events;
			if (reg_we_i && (reg_ofs_i == periph_pkg::IRQ_MASK)) begin
				mask_q <= reg_wdat_i[periph_pkg::IRQ_N-1:0];
			end
		end
	end

	always_comb begin
		reg_rdat_o = '0;
		case (reg_ofs_i)
			periph_pkg::IRQ_PEND: reg_rdat_o[periph_pkg::IRQ_N-1:0] = pend_q;
			periph_pkg::IRQ_MASK: reg_rdat_o[periph_pkg::IRQ_N-1:0] = mask_q;
			default:              reg_rdat_o = '0;
		endcase
	end

	assign irq_o = |(pend_q & mask_q);

endmodule

/* src/periph_top.sv */
`timescale 1ns/100ps

module periph_top #(
	parameter int FIFO_DEPTH = 8,
	parameter int GPIO_W     = 8
) (
	input  logic                            wb_clk_i,
	input  logic                            rst_i,
	// Wishbone slave port
	input  logic                            wb_cyc_i,
	input  logic                            wb_stb_i,
	input  logic                            wb_we_i,
	input  logic [periph_pkg::BUS_AW-1:0]   wb_adr_i,
	input  logic [3:0]                      wb_sel_i,
	input  logic [periph_pkg::BUS_DW-1:0]   wb_dat_i,
	output logic [periph_pkg::BUS_DW-1:0]   wb_dat_o,
	output logic                            wb_ack_o,
	// GPIO, pads live outside
	input  logic [GPIO_W-1:0]               gpio_i,
	output logic [GPIO_W-1:0]               gpio_o,
	output logic [GPIO_W-1:0]               gpio_oe_o,
	// Streaming side
	input  logic [periph_pkg::REG_DW-1:0]   s2m_dat_i,
	input  logic                            s2m_we_i,
	output logic                            s2m_full_o,
	output logic                            s2m_empty_o,
	output logic [periph_pkg::REG_DW-1:0]   m2s_dat_o,
	input  logic                            m2s_re_i,
	output logic                            m2s_full_o,
	output logic                            m2s_empty_o,
	output logic                            irq_o
);

	logic [periph_pkg::REG_OFS_W-1:0] reg_ofs;
	logic [periph_pkg::REG_DW-1:0]    reg_wdat;
	logic [periph_pkg::REG_DW-1:0]    gpio_rdat;
	logic [periph_pkg::REG_DW-1:0]    fifo_rdat;
	logic [periph_pkg::REG_DW-1:0]    irq_rdat;
	logic                             gpio_we;
	logic                             fifo_we;
	logic                             fifo_re;
	logic                             irq_we;
	logic                             gpio_event;
	logic                             fifo_event;

	////////////////////////////////////////////////////////////
	// Bus controller
	////////////////////////////////////////////////////////////
	periph_bus_ctrl u_bus_ctrl (
		.wb_clk_i    (wb_clk_i),
		.rst_i       (rst_i),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_we_i     (wb_we_i),
		.wb_adr_i    (wb_adr_i),
		.wb_sel_i    (wb_sel_i),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o),
		.reg_ofs_o   (reg_ofs),
		.reg_wdat_o  (reg_wdat),
		.gpio_we_o   (gpio_we),
		.fifo_we_o   (fifo_we),
		.fifo_re_o   (fifo_re),
		.irq_we_o    (irq_we),
		.gpio_rdat_i (gpio_rdat),
		.fifo_rdat_i (fifo_rdat),
		.irq_rdat_i  (irq_rdat)
	);

	////////////////////////////////////////////////////////////
	// Register blocks
	////////////////////////////////////////////////////////////
	gpio_port #(
		.GPIO_W       (GPIO_W)
	) u_gpio (
		.wb_clk_i     (wb_clk_i),
		.rst_i        (rst_i),
		.reg_ofs_i    (reg_ofs),
		.reg_wdat_i   (reg_wdat),
		.reg_we_i     (gpio_we),
		.reg_rdat_o   (gpio_rdat),
		.gpio_i       (gpio_i),
		.gpio_o       (gpio_o),
		.gpio_oe_o    (gpio_oe_o),
		.gpio_event_o (gpio_event)
	);

	fifo_bridge #(
		.FIFO_DEPTH   (FIFO_DEPTH)
	) u_fifo (
		.wb_clk_i     (wb_clk_i),
		.rst_i        (rst_i),
		.reg_ofs_i    (reg_ofs),
		.reg_wdat_i   (reg_wdat),
		.reg_we_i     (fifo_we),
		.reg_re_i     (fifo_re),
		.reg_rdat_o   (fifo_rdat),
		.s2m_dat_i    (s2m_dat_i),
		.s2m_we_i     (s2m_we_i),
		.s2m_full_o   (s2m_full_o),
		.s2m_empty_o  (s2m_empty_o),
		.m2s_dat_o    (m2s_dat_o),
		.m2s_re_i     (m2s_re_i),
		.m2s_full_o   (m2s_full_o),
		.m2s_empty_o  (m2s_empty_o),
		.fifo_event_o (fifo_event)
	);

	irq_ctrl u_irq (
		.wb_clk_i     (wb_clk_i),
		.rst_i        (rst_i),
		.reg_ofs_i    (reg_ofs),
		.reg_wdat_i   (reg_wdat),
		.reg_we_i     (irq_we),
		.reg_rdat_o   (irq_rdat),
		.gpio_event_i (gpio_event),
		.fifo_event_i (fifo_event),
		.irq_o        (irq_o)
	);

endmodule

/* dv/periph_checker.sv */
`timescale 1ns/100ps

module periph_checker (
	input  logic                            clk_i,
	input  logic                            rst_i,
	input  logic                            cyc_i,
	input  logic                            stb_i,
	input  logic [3:0]                      sel_i,
	input  logic                            ack_i,
	input  logic [periph_pkg::IRQ_N-1:0]    pend_i,
	input  logic [periph_pkg::IRQ_N-1:0]    mask_i,
	input  logic                            irq_i
);

	logic req;

	assign req = cyc_i & stb_i;

	////////////////////////////////////////////////////////////
	// Bus handshake
	////////////////////////////////////////////////////////////
	// Fresh request gets ack in the next cycle
	a_ack_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
		(req && !ack_i) |=> ack_i)
		else $error("ack did not follow a fresh request after one cycle");

	// No ack without a request one cycle earlier
	a_ack_has_req: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_i |-> $past(req && !ack_i))
		else $error("ack raised without a preceding request");

	a_ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_i |=> !ack_i)
		else $error("ack stayed high for more than one cycle");

	a_sel_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
		stb_i |-> $onehot(sel_i))
		else $error("byte select is not one-hot during a request");

	////////////////////////////////////////////////////////////
	// Interrupt output
	////////////////////////////////////////////////////////////
	a_irq_level: assert property (@(posedge clk_i) disable iff (rst_i)
		irq_i == |(pend_i & mask_i))
		else $error("irq output does not match pending and mask");

endmodule

// Bus side, interrupt inputs tied idle
bind periph_bus_ctrl periph_checker u_bus_chk (
	.clk_i  (wb_clk_i),
	.rst_i  (rst_i),
	.cyc_i  (wb_cyc_i),
	.stb_i  (wb_stb_i),
	.sel_i  (wb_sel_i),
	.ack_i  (wb_ack_o),
	.pend_i ('0),
	.mask_i ('0),
	.irq_i  (1'b0)
);

// Interrupt side, bus inputs tied idle
bind irq_ctrl periph_checker u_irq_chk (
	.clk_i  (wb_clk_i),
	.rst_i  (rst_i),
	.cyc_i  (1'b0),
	.stb_i  (1'b0),
	.sel_i  (4'b0001),
	.ack_i  (1'b0),
	.pend_i (pend_q),
	.mask_i (mask_q),
	.irq_i  (irq_o)
);

/* dv/periph_tb.sv */
`timescale 1ns/100ps

module periph_tb;

	localparam int FIFO_DEPTH = 8;
	localparam int CLK_NS     = 4;
	// Twice the time of 200 three-cycle transactions
	localparam int WATCHDOG_NS = 200 * 3 * CLK_NS * 2;

	localparam logic [3:0] GPIO_BLK = 4'h0;
	localparam logic [3:0] FIFO_BLK = 4'h1;
	localparam logic [3:0] IRQ_BLK  = 4'h2;
	localparam logic [3:0] NONE_BLK = 4'h8;
	localparam logic [3:0] SEL0     = 4'b0001;

	logic        wb_clk_i;
	logic        rst_i;
	logic        wb_cyc_i;
	logic        wb_stb_i;
	logic        wb_we_i;
	logic [7:0]  wb_adr_i;
	logic [3:0]  wb_sel_i;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic        wb_ack_o;
	logic [7:0]  gpio_i;
	logic [7:0]  gpio_o;
	logic [7:0]  gpio_oe_o;
	logic [7:0]  s2m_dat_i;
	logic        s2m_we_i;
	logic        s2m_full_o;
	logic        s2m_empty_o;
	logic [7:0]  m2s_dat_o;
	logic        m2s_re_i;
	logic        m2s_full_o;
	logic        m2s_empty_o;
	logic        irq_o;

	integer      seed;
	logic [31:0] rd;
	logic [31:0] wd;
	logic [7:0]  b;
	logic [7:0]  dir;
	logic [7:0]  out;
	logic [7:0]  pin;
	logic [7:0]  exp_q[$];

	periph_top #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.GPIO_W      (8)
	) uut (
		.wb_clk_i    (wb_clk_i),
		.rst_i       (rst_i),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_we_i     (wb_we_i),
		.wb_adr_i    (wb_adr_i),
		.wb_sel_i    (wb_sel_i),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o),
		.gpio_i      (gpio_i),
		.gpio_o      (gpio_o),
		.gpio_oe_o   (gpio_oe_o),
		.s2m_dat_i   (s2m_dat_i),
		.s2m_we_i    (s2m_we_i),
		.s2m_full_o  (s2m_full_o),
		.s2m_empty_o (s2m_empty_o),
		.m2s_dat_o   (m2s_dat_o),
		.m2s_re_i    (m2s_re_i),
		.m2s_full_o  (m2s_full_o),
		.m2s_empty_o (m2s_empty_o),
		.irq_o       (irq_o)
	);

	initial begin
		wb_clk_i = 1'b0;
		forever #(CLK_NS / 2) wb_clk_i = ~wb_clk_i;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: watchdog expired before the tests finished");
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped by watchdog");
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	function automatic logic [7:0] reg_adr(input logic [3:0] blk, input logic [1:0] ofs);
		return {blk, 2'b00, ofs};
	endfunction

	function automatic logic [31:0] all_lanes(input logic [7:0] val);
		return {4{val}};
	endfunction

	// FIFO_STAT layout from bit 0 upward
	function automatic logic [7:0] stat_byte(input logic s2m_e, input logic s2m_f,
		input logic m2s_e, input logic m2s_f);
		return {4'b0000, m2s_f, m2s_e, s2m_f, s2m_e};
	endfunction

	task automatic expect_eq(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
			$display("ERRORS FOUND");
			$fatal(1, "first error stops the run");
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge wb_clk_i);
		#1;
	endtask

	task automatic wait_ack();
		do begin
			@(posedge wb_clk_i);
			#1;
		end while (!wb_ack_o);
	endtask

	task automatic end_cycle();
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		wait_cycles(1);
	endtask

	task automatic bus_write(input logic [7:0] adr, input logic [3:0] sel,
		input logic [31:0] dat);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b1;
		wb_adr_i = adr;
		wb_sel_i = sel;
		wb_dat_i = dat;
		wait_ack();
		end_cycle();
	endtask

	task automatic bus_read(input logic [7:0] adr, input logic [3:0] sel,
		output logic [31:0] dat);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = 1'b0;
		wb_adr_i = adr;
		wb_sel_i = sel;
		wait_ack();
		dat = wb_dat_o;
		end_cycle();
	endtask

	task automatic push_s2m(input logic [7:0] val);
		s2m_dat_i = val;
		s2m_we_i  = 1'b1;
		wait_cycles(1);
		s2m_we_i  = 1'b0;
	endtask

	task automatic pop_m2s();
		m2s_re_i = 1'b1;
		wait_cycles(1);
		m2s_re_i = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	initial begin
		seed      = 46388;
		rst_i     = 1'b1;
		wb_cyc_i  = 1'b0;
		wb_stb_i  = 1'b0;
		wb_we_i   = 1'b0;
		wb_adr_i  = '0;
		wb_sel_i  = SEL0;
		wb_dat_i  = '0;
		gpio_i    = '0;
		s2m_dat_i = '0;
		s2m_we_i  = 1'b0;
		m2s_re_i  = 1'b0;
		wait_cycles(5);
		rst_i = 1'b0;

		expect_eq("reset ack", 32'd0, 32'(wb_ack_o));
		expect_eq("reset gpio_oe", 32'd0, 32'(gpio_oe_o));
		expect_eq("reset gpio_o", 32'd0, 32'(gpio_o));
		expect_eq("reset irq", 32'd0, 32'(irq_o));
		expect_eq("reset fifo flags", 32'h5,
			32'({m2s_full_o, m2s_empty_o, s2m_full_o, s2m_empty_o}));

		// GPIO direction, output and mixed read-back
		for (int i = 0; i < 8; i++) begin
			dir = 8'($random(seed));
			out = 8'($random(seed));
			pin = 8'($random(seed));
			bus_write(reg_adr(GPIO_BLK, periph_pkg::GPIO_DIR), SEL0, all_lanes(dir));
			bus_write(reg_adr(GPIO_BLK, periph_pkg::GPIO_DATA), SEL0, all_lanes(out));
			gpio_i = pin;
			expect_eq("gpio oe", 32'(dir), 32'(gpio_oe_o));
			expect_eq("gpio out", 32'(out), 32'(gpio_o));
			wait_cycles(2);
			bus_read(reg_adr(GPIO_BLK, periph_pkg::GPIO_DATA), SEL0, rd);
			expect_eq("gpio read", all_lanes((out & dir) | (pin & ~dir)), rd);
			bus_read(reg_adr(GPIO_BLK, periph_pkg::GPIO_DIR), SEL0, rd);
			expect_eq("gpio dir read", all_lanes(dir), rd);
		end

		// Each byte lane narrows to the register
		for (int lane = 0; lane < 4; lane++) begin
			wd = $random(seed);
			bus_write(reg_adr(GPIO_BLK, periph_pkg::GPIO_DIR), 4'(1 << lane), wd);
			bus_read(reg_adr(GPIO_BLK, periph_pkg::GPIO_DIR), 4'(1 << lane), rd);
			expect_eq("byte lane", all_lanes(wd[lane*8 +: 8]), rd);
		end
		bus_write(reg_adr(NONE_BLK, periph_pkg::GPIO_DIR), SEL0, 32'hffff_ffff);
		bus_read(reg_adr(NONE_BLK, periph_pkg::GPIO_DIR), SEL0, rd);
		expect_eq("unmapped read", 32'h0, rd);
		expect_eq("unmapped write", 32'(wd[31:24]), 32'(gpio_oe_o));

		// m2s fill, overflow drop, drain in order
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			b = 8'($random(seed));
			exp_q.push_back(b);
			bus_write(reg_adr(FIFO_BLK, periph_pkg::FIFO_DATA), SEL0, all_lanes(b));
		end
		bus_read(reg_adr(FIFO_BLK, periph_pkg::FIFO_STAT), SEL0, rd);
		expect_eq("m2s full stat", all_lanes(stat_byte(1'b1, 1'b0, 1'b0, 1'b1)), rd);
		expect_eq("m2s full flags", 32'(stat_byte(1'b1, 1'b0, 1'b0, 1'b1)),
			32'({m2s_full_o, m2s_empty_o, s2m_full_o, s2m_empty_o}));
		bus_write(reg_adr(FIFO_BLK, periph_pkg::FIFO_DATA), SEL0, all_lanes(~exp_q[0]));
		while (exp_q.size() > 0) begin
			b = exp_q.pop_front();
			expect_eq("m2s order", 32'(b), 32'(m2s_dat_o));
			pop_m2s();
		end
		expect_eq("m2s drop", 32'd1, 32'(m2s_empty_o));

		// s2m fill with one extra push, then drain over the bus
		for (int i = 0; i <= FIFO_DEPTH; i++) begin
			b = 8'($random(seed));
			if (i < FIFO_DEPTH) begin
				exp_q.push_back(b);
			end
			push_s2m(b);
		end
		expect_eq("irq masked", 32'd0, 32'(irq_o));
		bus_read(reg_adr(FIFO_BLK, periph_pkg::FIFO_STAT), SEL0, rd);
		expect_eq("s2m full stat", all_lanes(stat_byte(1'b0, 1'b1, 1'b1, 1'b0)), rd);
		expect_eq("s2m full flags", 32'(stat_byte(1'b0, 1'b1, 1'b1, 1'b0)),
			32'({m2s_full_o, m2s_empty_o, s2m_full_o, s2m_empty_o}));
		while (exp_q.size() > 0) begin
			b = exp_q.pop_front();
			bus_read(reg_adr(FIFO_BLK, periph_pkg::FIFO_DATA), SEL0, rd);
			expect_eq("s2m order", all_lanes(b), rd);
		end
		bus_read(reg_adr(FIFO_BLK, periph_pkg::FIFO_DATA), SEL0, rd);
		expect_eq("s2m empty read", 32'h0, rd);
		bus_read(reg_adr(FIFO_BLK, periph_pkg::FIFO_STAT), SEL0, rd);
		expect_eq("s2m empty stat", all_lanes(stat_byte(1'b1, 1'b0, 1'b1, 1'b0)), rd);
		expect_eq("s2m empty flags", 32'(stat_byte(1'b1, 1'b0, 1'b1, 1'b0)),
			32'({m2s_full_o, m2s_empty_o, s2m_full_o, s2m_empty_o}));

		// Interrupts
		bus_write(reg_adr(IRQ_BLK, periph_pkg::IRQ_PEND), SEL0, all_lanes(8'h03));
		bus_read(reg_adr(IRQ_BLK, periph_pkg::IRQ_PEND), SEL0, rd);
		expect_eq("irq cleared", 32'h0, rd);
		gpio_i = ~gpio_i;
		wait_cycles(3);
		bus_read(reg_adr(IRQ_BLK, periph_pkg::IRQ_PEND), SEL0, rd);
		expect_eq("gpio pending", all_lanes(8'h01), rd);
		expect_eq("irq low while masked", 32'd0, 32'(irq_o));
		bus_write(reg_adr(IRQ_BLK, periph_pkg::IRQ_MASK), SEL0, all_lanes(8'h03));
		bus_read(reg_adr(IRQ_BLK, periph_pkg::IRQ_MASK), SEL0, rd);
		expect_eq("irq mask read", all_lanes(8'h03), rd);
		expect_eq("irq raised", 32'd1, 32'(irq_o));
		bus_write(reg_adr(IRQ_BLK, periph_pkg::IRQ_PEND), SEL0, all_lanes(8'h01));
		expect_eq("irq gpio cleared", 32'd0, 32'(irq_o));

		// FIFO source holds its pending bit until drained
		b = 8'($random(seed));
		push_s2m(b);
		wait_cycles(2);
		expect_eq("irq fifo raised", 32'd1, 32'(irq_o));
		bus_write(reg_adr(IRQ_BLK, periph_pkg::IRQ_PEND), SEL0, all_lanes(8'h02));
		bus_read(reg_adr(IRQ_BLK, periph_pkg::IRQ_PEND), SEL0, rd);
		expect_eq("fifo pending held", all_lanes(8'h02), rd);
		bus_read(reg_adr(FIFO_BLK, periph_pkg::FIFO_DATA), SEL0, rd);
		expect_eq("s2m irq data", all_lanes(b), rd);
		bus_write(reg_adr(IRQ_BLK, periph_pkg::IRQ_PEND), SEL0, all_lanes(8'h02));
		bus_read(reg_adr(IRQ_BLK, periph_pkg::IRQ_PEND), SEL0, rd);
		expect_eq("fifo pending cleared", 32'h0, rd);
		expect_eq("irq final", 32'd0, 32'(irq_o));

		$display("NO ERRORS");
		$finish;
	end

endmodule

/* build.f */
src/periph_pkg.sv
src/stream_fifo.sv
src/periph_bus_ctrl.sv
src/gpio_port.sv
src/fifo_bridge.sv
src/irq_ctrl.sv
src/periph_top.sv
dv/periph_checker.sv
dv/periph_tb.sv

/* Makefile */
SRCS := $(wildcard src/*.sv dv/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vperiph_tb: build.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module periph_tb -Mdir obj_dir -f build.f

run: obj_dir/Vperiph_tb
	./obj_dir/Vperiph_tb | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
